// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for a failure
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_dummy_hint \
  --Mdir "$BUILD_DIR" \
  -o tb_dummy_hint \
  -f verilog.f

"$BUILD_DIR/tb_dummy_hint" | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "Testbench reported a failure, see $LOG"
  exit 1
fi

echo "No failure found in $LOG"

// File: tb/tb_dummy_hint.sv
/*
 * Directed testbench for the dummy and hint insertion block. Covers pass-through,
 * dummy windows, hint replacement, seeding and back-pressure against a reference
 * LFSR model that predicts every random word and operand.
 */
`timescale 1ns/1ps

module tb_dummy_hint;

  import dummy_hint_pkg::*;

  localparam int unsigned CYCLE_LIMIT = 2000;
  localparam logic [XLEN-1:0] FALLBACK [3] = '{LFSR0_DEFAULT, LFSR1_DEFAULT, LFSR2_DEFAULT};

  logic            clk_i;
  logic            rst_ni;
  logic            fetch_valid;
  logic [XLEN-1:0] fetch_instr;
  logic            fetch_ready;
  logic            issue_valid;
  issue_t          issue;
  logic            id_ready;
  logic            rnddummy_enabled;
  logic            rndhint_enabled;
  logic [3:0]      dummy_freq;
  seed_wr_t        seed0;
  seed_wr_t        seed1;
  seed_wr_t        seed2;

  logic [XLEN-1:0] model [3];
  int unsigned     checks;
  int unsigned     errors;

  dummy_hint_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [XLEN-1:0] galois_next(input logic [XLEN-1:0] s,
                                                  input logic [XLEN-1:0] fallback);
    logic [XLEN-1:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    if (n == '0) begin
      n = fallback;
    end
    return n;
  endfunction

  // All three generators move together on every accepted dummy or hint
  task automatic advance_model();
    for (int i = 0; i < 3; i++) begin
      model[i] = galois_next(model[i], FALLBACK[i]);
    end
  endtask

  function automatic instr_word_u expected_word(input logic [XLEN-1:0] r0, input logic hint);
    instr_word_u w;
    logic [12:0] off;
    w = '0;
    off = hint ? HINT_BRANCH_OFFSET : DUMMY_BRANCH_OFFSET;
    w.r.rs1 = r0[6:2];
    w.r.rs2 = r0[11:7];
    case (dummy_op_e'(r0[1:0]))
      ADD: begin
        w.r.opcode = OPCODE_OP;
        w.r.funct3 = FUNCT3_ADD;
        w.r.funct7 = FUNCT7_ADD;
      end
      AND: begin
        w.r.opcode = OPCODE_OP;
        w.r.funct3 = FUNCT3_AND;
        w.r.funct7 = FUNCT7_ADD;
      end
      MUL: begin
        w.r.opcode = OPCODE_OP;
        w.r.funct3 = FUNCT3_MUL;
        w.r.funct7 = FUNCT7_MUL;
      end
      default: begin
        w.b.opcode   = OPCODE_BRANCH;
        w.b.funct3   = FUNCT3_BLTU;
        w.b.imm_12   = off[12];
        w.b.imm_11   = off[11];
        w.b.imm_10_5 = off[10:5];
        w.b.imm_4_1  = off[4:1];
      end
    endcase
    return w;
  endfunction

  function automatic issue_t make_issue(input instr_word_u word, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b, input logic dummy,
                                        input logic hint);
    issue_t it;
    it.instr     = word;
    it.operand_a = a;
    it.operand_b = b;
    it.dummy     = dummy;
    it.hint      = hint;
    return it;
  endfunction

  // Low bits 11 mark a full-width instruction, so it never looks like a hint
  function automatic logic [XLEN-1:0] random_word();
    logic [XLEN-1:0] w;
    w = $urandom;
    w[1:0] = 2'b11;
    return w;
  endfunction

  // c.slli x0 in the low half, the upper half is noise the detector ignores
  function automatic logic [XLEN-1:0] hint_word(input logic [5:0] shamt);
    logic [15:0] upper;
    upper = 16'($urandom);
    return {upper, FUNCT3_C_SLLI, shamt[5], REG_X0, shamt[4:0], OPCODE_C_SLLI};
  endfunction

  task automatic check_issue(input issue_t act, input issue_t exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s issue %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_word(input instr_word_u act, input instr_word_u exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s word %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_lfsr(input logic [XLEN-1:0] act, input logic [XLEN-1:0] exp,
                            input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s value %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_level(input logic act, input logic exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  task automatic drive_cycle(input logic valid, input logic [XLEN-1:0] instr, input logic ready);
    @(negedge clk_i);
    fetch_valid = valid;
    fetch_instr = instr;
    id_ready    = ready;
    #1;
  endtask

  task automatic set_controls(input logic dummy_en, input logic hint_en, input logic [3:0] freq);
    @(negedge clk_i);
    fetch_valid      = 1'b0;
    id_ready         = 1'b0;
    rnddummy_enabled = dummy_en;
    rndhint_enabled  = hint_en;
    dummy_freq       = freq;
  endtask

  task automatic write_seed(input int idx, input logic [XLEN-1:0] value);
    seed_wr_t wr;
    wr.we    = 1'b1;
    wr.value = value;
    @(negedge clk_i);
    fetch_valid = 1'b0;
    id_ready    = 1'b0;
    case (idx)
      0: seed0 = wr;
      1: seed1 = wr;
      default: seed2 = wr;
    endcase
    @(negedge clk_i);
    seed0.we = 1'b0;
    seed1.we = 1'b0;
    seed2.we = 1'b0;
    model[idx] = (value == '0) ? FALLBACK[idx] : value;
  endtask

  // A shown dummy has to match the model before the generators move on
  task automatic check_dummy();
    check_word(issue.instr, expected_word(model[0], 1'b0), "dummy");
    check_lfsr(issue.operand_a, model[1], "dummy operand_a");
    check_lfsr(issue.operand_b, model[2], "dummy operand_b");
    check_level(issue.hint, 1'b0, "dummy hint flag");
  endtask

  task automatic test_pass_through();
    logic [XLEN-1:0] w;
    set_controls(1'b0, 1'b0, 4'd0);
    for (int i = 0; i < 12; i++) begin
      w = (i % 3 == 0) ? hint_word(6'(i + 1)) : random_word();
      drive_cycle(1'b1, w, 1'b1);
      check_level(issue_valid, 1'b1, "pass-through valid");
      check_level(fetch_ready, 1'b1, "pass-through fetch_ready");
      check_issue(issue, make_issue(instr_word_u'(w), '0, '0, 1'b0, 1'b0), "pass-through");
    end
  endtask

  task automatic test_dummy_window(input logic [3:0] freq, input int unsigned window);
    int unsigned normals;
    int unsigned dummies;
    int unsigned cycles;
    logic        ready;
    normals = 0;
    dummies = 0;
    cycles  = 0;
    set_controls(1'b0, 1'b0, freq);
    set_controls(1'b1, 1'b0, freq);
    while (dummies < 3 && cycles < CYCLE_LIMIT) begin
      ready = 1'($urandom);
      drive_cycle(1'b1, random_word(), ready);
      cycles++;
      if (issue.dummy) begin
        check_level(fetch_ready, 1'b0, "fetch_ready under dummy");
        if (ready) begin
          check_dummy();
          advance_model();
          normals = 0;
          dummies++;
        end
      end else if (ready) begin
        normals++;
        checks++;
        if (normals > window) begin
          errors++;
          $display("[FAIL] %0t: %0d normal instructions without a dummy, window %0d",
                   $time, normals, window);
        end
      end
    end
    if (dummies < 3) begin
      errors++;
      $display("Timeout: fewer than 3 dummies in %0d cycles at setting %0d", CYCLE_LIMIT, freq);
    end
  endtask

  task automatic test_hints();
    issue_t      exp;
    int unsigned branches;
    branches = 0;
    set_controls(1'b0, 1'b1, 4'd0);
    for (int i = 0; i < 40; i++) begin
      drive_cycle(1'b1, hint_word(6'($urandom_range(63, 1))), 1'b1);
      exp = make_issue(expected_word(model[0], 1'b1), model[1], model[2], 1'b0, 1'b1);
      check_issue(issue, exp, "hint replacement");
      check_level(fetch_ready, 1'b1, "hint fetch_ready");
      if (dummy_op_e'(model[0][1:0]) == BLTU) begin
        branches++;
      end
      advance_model();
    end
    if (branches == 0) begin
      errors++;
      $display("No hint was replaced by a BLTU, so the branch offset went unchecked");
    end
    drive_cycle(1'b1, hint_word(6'd0), 1'b1);
    check_issue(issue, make_issue(instr_word_u'(fetch_instr), '0, '0, 1'b0, 1'b0), "zero shamt");
  endtask

  task automatic test_seeding();
    logic [XLEN-1:0] s1;
    s1 = $urandom | 32'h1;
    set_controls(1'b0, 1'b1, 4'd0);
    write_seed(0, $urandom);
    write_seed(1, s1);
    write_seed(2, '0);
    drive_cycle(1'b1, hint_word(6'd9), 1'b1);
    check_word(issue.instr, expected_word(model[0], 1'b1), "seeded hint");
    check_lfsr(issue.operand_a, s1, "seeded operand_a");
    check_lfsr(issue.operand_b, LFSR2_DEFAULT, "zero seed fallback");
    advance_model();
  endtask

  task automatic test_back_pressure();
    issue_t      held;
    logic        shown;
    int unsigned cycles;
    shown  = 1'b0;
    cycles = 0;
    set_controls(1'b0, 1'b0, 4'd0);
    set_controls(1'b1, 1'b0, 4'd0);
    // dummy_due comes from a register, so a pending dummy shows before the inputs change
    while (!shown && cycles < CYCLE_LIMIT) begin
      @(negedge clk_i);
      shown       = issue.dummy;
      fetch_valid = 1'b1;
      fetch_instr = random_word();
      id_ready    = !shown;
      cycles++;
    end
    if (!shown) begin
      errors++;
      $display("Timeout: no dummy appeared for the back-pressure test");
    end else begin
      #1;
      held = issue;
      check_dummy();
      // A shown dummy stays valid whether or not fetch has a word waiting
      for (int i = 0; i < 4; i++) begin
        drive_cycle(i[0], random_word(), 1'b0);
        check_issue(issue, held, "dummy held under back-pressure");
        check_level(issue_valid, 1'b1, "dummy valid under back-pressure");
        check_level(fetch_ready, 1'b0, "fetch_ready under back-pressure");
      end
      drive_cycle(1'b1, random_word(), 1'b1);
      check_issue(issue, held, "released dummy");
      advance_model();
      drive_cycle(1'b0, '0, 1'b0);
    end
  endtask

  initial begin
    void'($urandom(32'h9f84fc19));
    checks           = 0;
    errors           = 0;
    rst_ni           = 1'b0;
    fetch_valid      = 1'b0;
    fetch_instr      = '0;
    id_ready         = 1'b0;
    rnddummy_enabled = 1'b0;
    rndhint_enabled  = 1'b0;
    dummy_freq       = 4'd0;
    seed0            = '0;
    seed1            = '0;
    seed2            = '0;
    for (int i = 0; i < 3; i++) begin
      model[i] = FALLBACK[i];
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    check_level(issue_valid, 1'b0, "issue_valid after reset");

    test_pass_through();
    test_dummy_window(4'd0, 4);
    test_dummy_window(FREQ_MIN_8, 8);
    test_dummy_window(4'($urandom_range(3, 2)), 16);
    test_dummy_window(4'($urandom_range(7, 4)), 32);
    test_dummy_window(4'($urandom_range(15, 8)), 64);
    test_hints();
    test_seeding();
    test_back_pressure();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/dummy_hint_pkg.sv
verilog/lfsr_seeded.sv
verilog/dummy_freq_counter.sv
verilog/dummy_instr_encoder.sv
verilog/fetch_issue_mux.sv
verilog/dummy_hint_top.sv
tb/tb_dummy_hint.sv

// File: verilog/dummy_freq_counter.sv
/*
 * Counts normal instructions handed to decode and requests a dummy once
 * the count reaches a random threshold inside the selected window.
 */
`timescale 1ns/1ps

module dummy_freq_counter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            enabled,
  input  logic [3:0]                      dummy_freq,
  input  logic [dummy_hint_pkg::XLEN-1:0] lfsr0,
  input  logic                            normal_accept,
  input  logic                            dummy_accept,
  output logic                            dummy_due
);

  import dummy_hint_pkg::*;

  logic [5:0] win_mask;
  logic [6:0] thr_new;
  logic [6:0] thr_cur;
  logic [6:0] thr_q;
  logic [6:0] cnt_q;
  logic [6:0] cnt_inc;
  logic       reload_q;
  logic       due_q;

  // Window size minus one, used as a modulo mask on the random bits
  always_comb begin
    if (dummy_freq >= FREQ_MIN_64) begin
      win_mask = 6'd63;
    end else if (dummy_freq >= FREQ_MIN_32) begin
      win_mask = 6'd31;
    end else if (dummy_freq >= FREQ_MIN_16) begin
      win_mask = 6'd15;
    end else if (dummy_freq >= FREQ_MIN_8) begin
      win_mask = 6'd7;
    end else begin
      win_mask = 6'd3;
    end
  end

  assign thr_new = 7'd1 + {1'b0, lfsr0[31:26] & win_mask};

  // In the reload cycle the stored threshold is stale, so compare against the new one
  assign thr_cur = reload_q ? thr_new : thr_q;
  assign cnt_inc = cnt_q + 7'd1;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || !enabled) begin
      cnt_q    <= '0;
      due_q    <= 1'b0;
      reload_q <= 1'b1;
    end else if (dummy_accept) begin
      cnt_q    <= '0;
      due_q    <= 1'b0;
      reload_q <= 1'b1;
    end else begin
      reload_q <= 1'b0;
      if (normal_accept) begin
        cnt_q <= cnt_inc;
        if (cnt_inc >= thr_cur) begin
          due_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reload_q) begin
      thr_q <= thr_new;
    end
  end

  assign dummy_due = due_q && enabled;

endmodule

// File: verilog/dummy_hint_pkg.sv
/*
 * Shared constants and types for the dummy and hint instruction block.
 * Imported by every RTL module of the fetch-stage insertion logic.
 */
package dummy_hint_pkg;

  localparam int unsigned XLEN = 32;

  // Right-shifting Galois mask for x^32 + x^22 + x^2 + x + 1
  localparam logic [XLEN-1:0] LFSR_TAPS = 32'h8020_0003;

  // Fallback values loaded when an LFSR would otherwise go to zero
  localparam logic [XLEN-1:0] LFSR0_DEFAULT = 32'hac53_3bf4;
  localparam logic [XLEN-1:0] LFSR1_DEFAULT = 32'h5a56_3a3d;
  localparam logic [XLEN-1:0] LFSR2_DEFAULT = 32'hd9c5_4e4c;

  // Lower bound of each dummy frequency range, a setting of 0 selects a window of 4
  localparam logic [3:0] FREQ_MIN_8  = 4'd1;
  localparam logic [3:0] FREQ_MIN_16 = 4'd2;
  localparam logic [3:0] FREQ_MIN_32 = 4'd4;
  localparam logic [3:0] FREQ_MIN_64 = 4'd8;

  // Branch offsets in bytes, a hint replaces a 2-byte compressed instruction
  localparam logic [12:0] DUMMY_BRANCH_OFFSET = 13'd0;
  localparam logic [12:0] HINT_BRANCH_OFFSET  = 13'd2;

  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [6:0] FUNCT7_ADD  = 7'b0000000;
  localparam logic [6:0] FUNCT7_MUL  = 7'b0000001;

  localparam logic [1:0] OPCODE_C_SLLI = 2'b10;
  localparam logic [2:0] FUNCT3_C_SLLI = 3'b000;

  localparam logic [4:0] REG_X0 = 5'd0;

  typedef enum logic [1:0] {
    ADD  = 2'd0,
    AND  = 2'd1,
    MUL  = 2'd2,
    BLTU = 2'd3
  } dummy_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  // The same instruction word seen as an R-type or a B-type encoding
  typedef union packed {
    r_type_t r;
    b_type_t b;
  } instr_word_u;

  typedef struct packed {
    logic            we;
    logic [XLEN-1:0] value;
  } seed_wr_t;

  typedef struct packed {
    instr_word_u     instr;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            dummy;
    logic            hint;
  } issue_t;

endpackage

// File: verilog/dummy_hint_top.sv
/*
 * Dummy and hint instruction insertion between fetch and decode.
 * Ties the three LFSRs, the frequency counter, the encoder and the issue mux.
 */
`timescale 1ns/1ps

module dummy_hint_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            fetch_valid,
  input  logic [dummy_hint_pkg::XLEN-1:0] fetch_instr,
  output logic                            fetch_ready,
  output logic                            issue_valid,
  output dummy_hint_pkg::issue_t          issue,
  input  logic                            id_ready,
  input  logic                            rnddummy_enabled,
  input  logic                            rndhint_enabled,
  input  logic [3:0]                      dummy_freq,
  input  dummy_hint_pkg::seed_wr_t        seed0,
  input  dummy_hint_pkg::seed_wr_t        seed1,
  input  dummy_hint_pkg::seed_wr_t        seed2
);

  import dummy_hint_pkg::*;

  logic [XLEN-1:0] lfsr0;
  logic [XLEN-1:0] lfsr1;
  logic [XLEN-1:0] lfsr2;
  logic [XLEN-1:0] enc_operand_a;
  logic [XLEN-1:0] enc_operand_b;
  instr_word_u     enc_word;
  logic            lfsr_step;
  logic            is_hint;
  logic            dummy_due;
  logic            dummy_accept;
  logic            hint_accept;
  logic            normal_accept;

  // Every issued dummy or hint consumes fresh random bits
  assign lfsr_step = dummy_accept || hint_accept;

  lfsr_seeded #(.DEFAULT_SEED(LFSR0_DEFAULT)) u_lfsr0 (
    .clk_i, .rst_ni, .step(lfsr_step), .seed_wr(seed0), .value(lfsr0)
  );

  lfsr_seeded #(.DEFAULT_SEED(LFSR1_DEFAULT)) u_lfsr1 (
    .clk_i, .rst_ni, .step(lfsr_step), .seed_wr(seed1), .value(lfsr1)
  );

  lfsr_seeded #(.DEFAULT_SEED(LFSR2_DEFAULT)) u_lfsr2 (
    .clk_i, .rst_ni, .step(lfsr_step), .seed_wr(seed2), .value(lfsr2)
  );

  dummy_freq_counter u_freq_counter (
    .clk_i,
    .rst_ni,
    .enabled      (rnddummy_enabled),
    .dummy_freq,
    .lfsr0,
    .normal_accept,
    .dummy_accept,
    .dummy_due
  );

  dummy_instr_encoder u_encoder (
    .lfsr0,
    .lfsr1,
    .lfsr2,
    .is_hint,
    .word      (enc_word),
    .operand_a (enc_operand_a),
    .operand_b (enc_operand_b)
  );

  fetch_issue_mux u_issue_mux (
    .fetch_valid, .fetch_instr, .id_ready, .dummy_due, .rndhint_enabled,
    .enc_word, .enc_operand_a, .enc_operand_b,
    .fetch_ready, .issue_valid, .issue, .is_hint,
    .dummy_accept, .hint_accept, .normal_accept
  );

endmodule

// File: verilog/dummy_instr_encoder.sv
/*
 * Builds the random ADD, AND, MUL or BLTU word from LFSR0 and takes the
 * operands from LFSR1 and LFSR2. Results always land in x0.
 */
`timescale 1ns/1ps

module dummy_instr_encoder (
  input  logic [dummy_hint_pkg::XLEN-1:0] lfsr0,
  input  logic [dummy_hint_pkg::XLEN-1:0] lfsr1,
  input  logic [dummy_hint_pkg::XLEN-1:0] lfsr2,
  input  logic                            is_hint,
  output dummy_hint_pkg::instr_word_u     word,
  output logic [dummy_hint_pkg::XLEN-1:0] operand_a,
  output logic [dummy_hint_pkg::XLEN-1:0] operand_b
);

  import dummy_hint_pkg::*;

  dummy_op_e   op;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [12:0] offset;

  assign op  = dummy_op_e'(lfsr0[1:0]);
  assign rs1 = lfsr0[6:2];
  assign rs2 = lfsr0[11:7];

  // A hint branch skips the 2-byte instruction it replaces
  assign offset = is_hint ? HINT_BRANCH_OFFSET : DUMMY_BRANCH_OFFSET;

  always_comb begin
    word        = '0;
    word.r.rs1  = rs1;
    word.r.rs2  = rs2;
    word.r.rd   = REG_X0;
    case (op)
      ADD: begin
        word.r.opcode = OPCODE_OP;
        word.r.funct3 = FUNCT3_ADD;
        word.r.funct7 = FUNCT7_ADD;
      end
      AND: begin
        word.r.opcode = OPCODE_OP;
        word.r.funct3 = FUNCT3_AND;
        word.r.funct7 = FUNCT7_ADD;
      end
      MUL: begin
        word.r.opcode = OPCODE_OP;
        word.r.funct3 = FUNCT3_MUL;
        word.r.funct7 = FUNCT7_MUL;
      end
      default: begin
        // BLTU has no rd, the immediate takes over those bits
        word.b.opcode   = OPCODE_BRANCH;
        word.b.funct3   = FUNCT3_BLTU;
        word.b.rs1      = rs1;
        word.b.rs2      = rs2;
        word.b.imm_12   = offset[12];
        word.b.imm_11   = offset[11];
        word.b.imm_10_5 = offset[10:5];
        word.b.imm_4_1  = offset[4:1];
      end
    endcase
  end

  assign operand_a = lfsr1;
  assign operand_b = lfsr2;

endmodule

// File: verilog/fetch_issue_mux.sv
/*
 * Selects what goes to decode: a dummy, a hint replacement or the fetched
 * word. Stalls fetch while a dummy is shown and pulses the accept strobes.
 */
`timescale 1ns/1ps

module fetch_issue_mux (
  input  logic                            fetch_valid,
  input  logic [dummy_hint_pkg::XLEN-1:0] fetch_instr,
  input  logic                            id_ready,
  input  logic                            dummy_due,
  input  logic                            rndhint_enabled,
  input  dummy_hint_pkg::instr_word_u     enc_word,
  input  logic [dummy_hint_pkg::XLEN-1:0] enc_operand_a,
  input  logic [dummy_hint_pkg::XLEN-1:0] enc_operand_b,
  output logic                            fetch_ready,
  output logic                            issue_valid,
  output dummy_hint_pkg::issue_t          issue,
  output logic                            is_hint,
  output logic                            dummy_accept,
  output logic                            hint_accept,
  output logic                            normal_accept
);

  import dummy_hint_pkg::*;

  logic       is_c_slli;
  logic [4:0] c_rd;
  logic [5:0] c_shamt;
  logic       hint_hit;

  // Compressed c.slli fields in the lower half of the fetched word
  assign c_rd      = fetch_instr[11:7];
  assign c_shamt   = {fetch_instr[12], fetch_instr[6:2]};
  assign is_c_slli = (fetch_instr[1:0] == OPCODE_C_SLLI) &&
                     (fetch_instr[15:13] == FUNCT3_C_SLLI);

  // c.slli x0 with a nonzero shift is a hint and may be replaced
  assign hint_hit = rndhint_enabled && is_c_slli && (c_rd == REG_X0) && (c_shamt != '0);
  assign is_hint  = hint_hit && !dummy_due;

  always_comb begin
    issue = '0;
    if (dummy_due) begin
      issue_valid     = 1'b1;
      issue.instr     = enc_word;
      issue.operand_a = enc_operand_a;
      issue.operand_b = enc_operand_b;
      issue.dummy     = 1'b1;
    end else if (hint_hit) begin
      issue_valid     = fetch_valid;
      issue.instr     = enc_word;
      issue.operand_a = enc_operand_a;
      issue.operand_b = enc_operand_b;
      issue.hint      = 1'b1;
    end else begin
      issue_valid     = fetch_valid;
      issue.instr     = fetch_instr;
    end
  end

  // The fetched word is held back for as long as a dummy sits in front of it
  assign fetch_ready   = fetch_valid && id_ready && !dummy_due;
  assign normal_accept = fetch_ready;
  assign hint_accept   = fetch_ready && hint_hit;
  assign dummy_accept  = dummy_due && id_ready;

endmodule

// File: verilog/lfsr_seeded.sv
/*
 * One 32-bit Galois LFSR with a seed write port and lockup recovery.
 * Steps once per accepted dummy or hint, a seed write wins over a step.
 */
`timescale 1ns/1ps

module lfsr_seeded #(
  parameter logic [dummy_hint_pkg::XLEN-1:0] DEFAULT_SEED = dummy_hint_pkg::LFSR0_DEFAULT
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             step,
  input  dummy_hint_pkg::seed_wr_t         seed_wr,
  output logic [dummy_hint_pkg::XLEN-1:0]  value
);

  import dummy_hint_pkg::*;

  logic [XLEN-1:0] lfsr_q;
  logic [XLEN-1:0] lfsr_step;
  logic [XLEN-1:0] lfsr_load;
  logic            load_en;

  // Shift right and fold the taps back in when a one falls out
  assign lfsr_step = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);

  always_comb begin
    load_en = seed_wr.we || step;
    if (seed_wr.we) begin
      lfsr_load = seed_wr.value;
    end else begin
      lfsr_load = lfsr_step;
    end
    // An all-zero state would never leave zero again
    if (lfsr_load == '0) begin
      lfsr_load = DEFAULT_SEED;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lfsr_q <= DEFAULT_SEED;
    end else if (load_en) begin
      lfsr_q <= lfsr_load;
    end
  end

  assign value = lfsr_q;

endmodule
